// ==== video_regs_top.f ====
+incdir+include
design/video_regs_pkg.sv
design/fault_sync.sv
design/fault_counter.sv
design/reg_map.sv
design/video_regs_top.sv
verif/reg_map_checker.sv
verif/video_regs_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the video register block testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f video_regs_top.f \
    --top-module video_regs_tb \
    -o sim_video_regs

./obj_dir/sim_video_regs | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

// ==== verif/video_regs_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// video scaler control register testbench
// directed tests of the config registers, osd ram port, console reset,
// fault counters with snapshot and clear, status and unmapped reads
////////////////////////////////////////////////////////////////////////////

`include "video_regs_params.svh"

module video_regs_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import video_regs_pkg::*;

    localparam int IDX_W = $clog2(`NUM_FAULTS);
    typedef logic [IDX_W-1:0] idx_t;

    logic                   clk;
    logic                   rst_n;
    reg_byte_t              addr;
    reg_byte_t              wdata;
    logic                   write_en;
    reg_byte_t              rdata;
    logic [`NUM_FAULTS-1:0] fault_in;
    logic [23:0]            status_word;
    reg_byte_t              ram_data;
    logic [9:0]             ram_wraddress;
    logic                   ram_wren;
    logic                   enable_osd;
    reg_byte_t              highlight_line;
    reg_byte_t              reconf_data;
    scanline_t              scanline;
    logic                   hdmi_out_en;
    colorspace_t            colorspace;
    logic                   reset_dc;

    int     errors;
    int     timeouts;
    integer seed;
    // model of every fault count, from the events driven
    count_t exp_cnt [`NUM_FAULTS];

    video_regs_top i_video_regs_top (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////

    task automatic compare_byte(input string name, input reg_byte_t exp, input reg_byte_t act);
        if (exp !== act) begin
            $display("error at %0t ns: %s expected %02h actual %02h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input count_t exp, input count_t act);
        if (exp !== act) begin
            $display("error at %0t ns: %s expected %08h actual %08h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error at %0t ns: %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // host port and fault line drivers
    ////////////////////////////////////////////////////////////////////////

    // one-cycle write strobe
    task automatic reg_write(input reg_byte_t a, input reg_byte_t d);
        @(posedge clk);
        addr     <= a;
        wdata    <= d;
        write_en <= 1'b1;
        @(posedge clk);
        write_en <= 1'b0;
    endtask

    // rdata follows the addr sampled one edge earlier
    task automatic reg_read(input reg_byte_t a, output reg_byte_t d);
        @(posedge clk);
        addr <= a;
        @(posedge clk);
        @(negedge clk);
        d = rdata;
    endtask

    // four bytes, msb first, the msb read takes the snapshot
    task automatic read_count(input idx_t idx, output count_t c);
        reg_byte_t b;
        count_t    v;
        v = '0;
        for (int k = 0; k < 4; k++) begin
            reg_read(`ADDR_CNT_BASE + reg_byte_t'(4 * idx + k), b);
            v = {v[23:0], b};
        end
        c = v;
    endtask

    // sel 0 waits for ram_wren, sel 1 for reset_dc
    task automatic wait_strobe(input bit sel, output bit seen);
        int n;
        n = 0;
        @(negedge clk);
        seen = sel ? reset_dc : ram_wren;
        while (!seen && n < 4) begin
            @(negedge clk);
            seen = sel ? reset_dc : ram_wren;
            n++;
        end
        if (!seen) begin
            $display("timeout: %s never pulsed after the write", sel ? "reset_dc" : "ram_wren");
            timeouts++;
        end
    endtask

    // one rising edge on a fault line, then back low long enough to re-arm
    task automatic fault_event(input idx_t idx);
        int n;
        @(posedge clk);
        fault_in[idx] <= 1'b1;
        n = 0;
        @(negedge clk);
        while (i_video_regs_top.fault_rise[idx] !== 1'b1 && n < 6) begin
            @(negedge clk);
            n++;
        end
        if (i_video_regs_top.fault_rise[idx] !== 1'b1) begin
            $display("timeout: fault line %0d rise was not detected", idx);
            timeouts++;
        end
        exp_cnt[idx] = exp_cnt[idx] + 32'd1;
        @(posedge clk);
        fault_in[idx] <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////

    task automatic test_reset_defaults();
        reg_byte_t r;
        compare_bit("ram_wren", 1'b0, ram_wren);
        compare_bit("reset_dc", 1'b0, reset_dc);
        compare_bit("enable_osd", 1'b0, enable_osd);
        compare_byte("highlight_line", 8'hFF, highlight_line);
        compare_byte("colorspace", 8'h00, {6'd0, colorspace});
        // intensity 0x100, flags clear
        compare_byte("scanline[11:4]", 8'h80, scanline[11:4]);
        compare_byte("scanline[3:0]", 8'h00, {4'd0, scanline[3:0]});
        reg_read(`ADDR_OSD_EN, r);
        compare_byte("rdata 0x81", 8'h00, r);
        reg_read(`ADDR_HIGHLIGHT, r);
        compare_byte("rdata 0x82", 8'hFF, r);
        reg_read(`ADDR_SCAN_HI, r);
        compare_byte("rdata 0x88", 8'h80, r);
        reg_read(`ADDR_SCAN_LO, r);
        compare_byte("rdata 0x89", 8'h00, r);
    endtask

    // random byte to one config address, check output and read-back
    task automatic config_check(input reg_byte_t a);
        reg_byte_t d;
        reg_byte_t r;
        reg_byte_t exp_v;
        reg_byte_t out_v;
        d = reg_byte_t'($random(seed));
        // second pass writes the inverse so every bit takes both values
        for (int p = 0; p < 2; p++) begin
            reg_write(a, d);
            @(negedge clk);
            // output as laid out in its register byte
            case (a)
                `ADDR_OSD_EN:    out_v = {7'd0, enable_osd};
                `ADDR_HIGHLIGHT: out_v = highlight_line;
                `ADDR_RECONF:    out_v = reconf_data;
                `ADDR_SCAN_HI:   out_v = scanline[11:4];
                `ADDR_SCAN_LO:   out_v = {scanline[3:0], 4'd0};
                `ADDR_HDMI_EN:   out_v = {7'd0, hdmi_out_en};
                default:         out_v = {6'd0, colorspace};
            endcase
            case (a)
                `ADDR_OSD_EN, `ADDR_HDMI_EN: exp_v = {7'd0, d[0]};
                // intensity lsb, thickness, oddeven, active
                `ADDR_SCAN_LO:    exp_v = {d[7:4], 4'd0};
                `ADDR_COLORSPACE: exp_v = {6'd0, d[1:0]};
                default:          exp_v = d;
            endcase
            compare_byte($sformatf("output of 0x%02h", a), exp_v, out_v);
            reg_read(a, r);
            compare_byte($sformatf("rdata 0x%02h", a), exp_v, r);
            d = ~d;
        end
    endtask

    task automatic test_config();
        config_check(`ADDR_OSD_EN);
        config_check(`ADDR_HIGHLIGHT);
        config_check(`ADDR_RECONF);
        config_check(`ADDR_SCAN_HI);
        config_check(`ADDR_SCAN_LO);
        config_check(`ADDR_HDMI_EN);
        config_check(`ADDR_COLORSPACE);
    endtask

    task automatic test_osd();
        reg_byte_t page;
        reg_byte_t a;
        reg_byte_t d;
        bit        seen;
        // nonzero page, so it differs from the reset page
        page = reg_byte_t'(1 + ($unsigned($random(seed)) % 7));
        reg_write(`ADDR_OSD_PAGE, page);
        reg_read(`ADDR_OSD_PAGE, d);
        compare_byte("rdata 0x80", page, d);
        repeat (4) begin
            a = reg_byte_t'($random(seed)) & 8'h7F;
            d = reg_byte_t'($random(seed));
            reg_write(a, d);
            wait_strobe(1'b0, seen);
            if (seen) begin
                compare_count("ram_wraddress", count_t'({page[2:0], a[6:0]}),
                              count_t'(ram_wraddress));
                compare_byte("ram_data", d, ram_data);
                // single pulse per write
                @(negedge clk);
                compare_bit("ram_wren", 1'b0, ram_wren);
            end
        end
    endtask

    task automatic test_console_reset();
        bit seen;
        reg_write(`ADDR_RESET_DC, 8'h01);
        wait_strobe(1'b1, seen);
        if (seen) begin
            @(negedge clk);
            compare_bit("reset_dc", 1'b0, reset_dc);
        end
        // neighbouring address leaves the console alone
        reg_write(`ADDR_RESET_DC + 8'd1, 8'h01);
        repeat (4) begin
            @(negedge clk);
            compare_bit("reset_dc", 1'b0, reset_dc);
        end
    endtask

    task automatic test_faults();
        int        n;
        count_t    c;
        count_t    snap_v;
        reg_byte_t b;
        for (int k = 0; k < `NUM_FAULTS; k++) begin
            n = 1 + ($unsigned($random(seed)) % 5);
            repeat (n) fault_event(idx_t'(k));
        end
        for (int k = 0; k < `NUM_FAULTS; k++) begin
            read_count(idx_t'(k), c);
            compare_count($sformatf("count %0d", k), exp_cnt[idx_t'(k)], c);
        end
        // msb read freezes counter 0, a later event must not show in bytes 1..3
        snap_v = exp_cnt[0];
        reg_read(`ADDR_CNT_BASE, b);
        compare_byte("count 0 byte 0", reg_byte_t'(snap_v >> 24), b);
        reg_read(8'hFE, b);
        compare_byte("rdata 0xfe", 8'h00, b);
        fault_event(idx_t'(0));
        for (int k = 1; k < 4; k++) begin
            reg_read(`ADDR_CNT_BASE + reg_byte_t'(k), b);
            compare_byte($sformatf("snapshot byte %0d", k),
                         reg_byte_t'(snap_v >> (24 - 8 * k)), b);
        end
        read_count(idx_t'(0), c);
        compare_count("count 0 after event", exp_cnt[0], c);
        // clear counters 0 and 2 only
        reg_write(`ADDR_CNT_CLEAR, 8'h05);
        for (int k = 0; k < `NUM_FAULTS; k++) begin
            if (k == 0 || k == 2) begin
                exp_cnt[idx_t'(k)] = '0;
            end
            read_count(idx_t'(k), c);
            compare_count($sformatf("count %0d after clear", k), exp_cnt[idx_t'(k)], c);
        end
    endtask

    task automatic test_status();
        logic [23:0] sw;
        reg_byte_t   b;
        sw = 24'($random(seed));
        @(posedge clk);
        status_word <= sw;
        for (int k = 0; k < 3; k++) begin
            reg_read(`ADDR_STATUS_BASE + reg_byte_t'(k), b);
            compare_byte($sformatf("status byte %0d", k), reg_byte_t'(sw >> (16 - 8 * k)), b);
        end
        reg_read(8'h84, b);
        compare_byte("rdata 0x84", 8'h00, b);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        addr        = '0;
        wdata       = '0;
        write_en    = 1'b0;
        fault_in    = '0;
        status_word = '0;
        errors      = 0;
        timeouts    = 0;
        seed        = 32'h52ae;
        exp_cnt     = '{default: '0};
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_reset_defaults();
        test_config();
        test_osd();
        test_console_reset();
        test_faults();
        test_status();
        $display("mismatches: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : video_regs_tb

// ==== verif/reg_map_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// register map assertions
// strobe widths on the osd ram and console reset, counter clear result
////////////////////////////////////////////////////////////////////////////

`include "video_regs_params.svh"

module reg_map_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   ram_wren,
    input logic                   reset_dc,
    input logic [`NUM_FAULTS-1:0] count_clear,
    input video_regs_pkg::count_t counts [`NUM_FAULTS]
);

    timeunit 1ns;
    timeprecision 100ps;

    // host paces writes, so no back-to-back ram strobes
    assert property (@(posedge clk) disable iff (!rst_n) ram_wren |=> !ram_wren)
        else $error("ram_wren high two cycles running");

    // console reset is a single cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) reset_dc |=> !reset_dc)
        else $error("reset_dc longer than one cycle");

    // cleared counter reads zero on the following cycle
    for (genvar i = 0; i < `NUM_FAULTS; i++) begin : g_clr
        assert property (@(posedge clk) disable iff (!rst_n)
            count_clear[i] |=> counts[i] == '0)
            else $error("counter %0d not zero after clear", i);
    end

endmodule : reg_map_checker

bind reg_map reg_map_checker i_reg_map_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .ram_wren    (ram_wren),
    .reset_dc    (reset_dc),
    .count_clear (count_clear),
    .counts      (counts)
);

// ==== design/video_regs_top.sv ====
////////////////////////////////////////////////////////////////////////////
// video scaler control register block
// fault synchroniser, one saturating counter per fault line and the
// host register map behind the i2c byte port
////////////////////////////////////////////////////////////////////////////

`include "video_regs_params.svh"

module video_regs_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // host byte port
    input  video_regs_pkg::reg_byte_t   addr,
    input  video_regs_pkg::reg_byte_t   wdata,
    input  logic                        write_en,
    output video_regs_pkg::reg_byte_t   rdata,
    // asynchronous fault levels and status
    input  logic [`NUM_FAULTS-1:0]      fault_in,
    input  logic [23:0]                 status_word,
    // osd character ram
    output video_regs_pkg::reg_byte_t   ram_data,
    output logic [9:0]                  ram_wraddress,
    output logic                        ram_wren,
    // video config
    output logic                        enable_osd,
    output video_regs_pkg::reg_byte_t   highlight_line,
    output video_regs_pkg::reg_byte_t   reconf_data,
    output video_regs_pkg::scanline_t   scanline,
    output logic                        hdmi_out_en,
    output video_regs_pkg::colorspace_t colorspace,
    output logic                        reset_dc
);

    import video_regs_pkg::*;

    // synced fault edges into the counters
    logic [`NUM_FAULTS-1:0] fault_rise;
    // clear strobes back from the register map
    logic [`NUM_FAULTS-1:0] count_clear;
    count_t                 counts [`NUM_FAULTS];

    fault_sync i_fault_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .fault_in   (fault_in),
        .fault_rise (fault_rise)
    );

    ////////////////////////////////////////////////////////////////////////
    // one counter per fault line
    ////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `NUM_FAULTS; i++) begin : g_cnt
        fault_counter i_fault_counter (
            .clk         (clk),
            .rst_n       (rst_n),
            .event_pulse (fault_rise[i]),
            .clear       (count_clear[i]),
            .count       (counts[i])
        );
    end

    reg_map i_reg_map (
        .clk            (clk),
        .rst_n          (rst_n),
        .addr           (addr),
        .wdata          (wdata),
        .write_en       (write_en),
        .rdata          (rdata),
        .status_word    (status_word),
        .counts         (counts),
        .count_clear    (count_clear),
        .ram_data       (ram_data),
        .ram_wraddress  (ram_wraddress),
        .ram_wren       (ram_wren),
        .enable_osd     (enable_osd),
        .highlight_line (highlight_line),
        .reconf_data    (reconf_data),
        .scanline       (scanline),
        .hdmi_out_en    (hdmi_out_en),
        .colorspace     (colorspace),
        .reset_dc       (reset_dc)
    );

endmodule : video_regs_top

// ==== design/reg_map.sv ====
////////////////////////////////////////////////////////////////////////////
// video scaler register map
// host byte write decode and registered read mux, osd ram write port,
// console reset strobe, fault counter clear and read snapshot
////////////////////////////////////////////////////////////////////////////

`include "video_regs_params.svh"

module reg_map (
    input  logic                        clk,
    input  logic                        rst_n,
    // host byte port
    input  video_regs_pkg::reg_byte_t   addr,
    input  video_regs_pkg::reg_byte_t   wdata,
    input  logic                        write_en,
    output video_regs_pkg::reg_byte_t   rdata,
    // status and fault counts
    input  logic [23:0]                 status_word,
    input  video_regs_pkg::count_t      counts [`NUM_FAULTS],
    output logic [`NUM_FAULTS-1:0]      count_clear,
    // osd character ram
    output video_regs_pkg::reg_byte_t   ram_data,
    output logic [9:0]                  ram_wraddress,
    output logic                        ram_wren,
    // video config
    output logic                        enable_osd,
    output video_regs_pkg::reg_byte_t   highlight_line,
    output video_regs_pkg::reg_byte_t   reconf_data,
    output video_regs_pkg::scanline_t   scanline,
    output logic                        hdmi_out_en,
    output video_regs_pkg::colorspace_t colorspace,
    output logic                        reset_dc
);

    import video_regs_pkg::*;

    // counter index bits inside the counter window
    localparam int IDX_W = $clog2(`NUM_FAULTS);

    // full strength, all flags off
    localparam scanline_t scanline_rst = '{
        intensity: 9'h100,
        thickness: 1'b0,
        oddeven:   1'b0,
        active:    1'b0
    };

    // osd page, top 3 bits of the ram address
    logic [2:0]       osd_page;

    // counter window decode
    reg_byte_t        cnt_off;
    logic             cnt_hit;
    logic [IDX_W-1:0] cnt_idx;
    logic [1:0]       cnt_byte;

    // per-counter copy taken on the msb read
    count_t           snap [`NUM_FAULTS];

    reg_byte_t        rd_next;

    ////////////////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            osd_page       <= '0;
            enable_osd     <= 1'b0;
            highlight_line <= 8'hFF;
            reconf_data    <= '0;
            scanline       <= scanline_rst;
            hdmi_out_en    <= 1'b0;
            colorspace     <= cs_rgb;
            ram_wren       <= 1'b0;
            reset_dc       <= 1'b0;
            count_clear    <= '0;
        end else begin
            // strobes last one cycle
            ram_wren    <= 1'b0;
            reset_dc    <= 1'b0;
            count_clear <= '0;
            if (write_en) begin
                // lower half of the map is osd character data
                if (!addr[7]) begin
                    ram_wren <= 1'b1;
                end
                case (addr)
                    `ADDR_OSD_PAGE:   osd_page       <= wdata[2:0];
                    `ADDR_OSD_EN:     enable_osd     <= wdata[0];
                    `ADDR_HIGHLIGHT:  highlight_line <= wdata;
                    `ADDR_RECONF:     reconf_data    <= wdata;
                    `ADDR_SCAN_HI:    scanline.intensity[8:1] <= wdata;
                    `ADDR_SCAN_LO: begin
                        // lsb of intensity shares the byte with the flags
                        scanline.intensity[0] <= wdata[7];
                        scanline.thickness    <= wdata[6];
                        scanline.oddeven      <= wdata[5];
                        scanline.active       <= wdata[4];
                    end
                    `ADDR_HDMI_EN:    hdmi_out_en    <= wdata[0];
                    `ADDR_COLORSPACE: colorspace     <= colorspace_t'(wdata[1:0]);
                    // one clear bit per counter
                    `ADDR_CNT_CLEAR:  count_clear    <= wdata[`NUM_FAULTS-1:0];
                    `ADDR_RESET_DC:   reset_dc       <= 1'b1;
                    // everything else is ignored
                    default: ;
                endcase
            end
        end
    end

    // osd ram address and data, qualified by ram_wren
    always_ff @(posedge clk) begin
        if (write_en && !addr[7]) begin
            ram_wraddress <= {osd_page, addr[6:0]};
            ram_data      <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // counter window and snapshot
    ////////////////////////////////////////////////////////////////////////

    // wraps high below the base, so one compare covers both ends
    assign cnt_off  = addr - `ADDR_CNT_BASE;
    assign cnt_hit  = cnt_off < reg_byte_t'(4 * `NUM_FAULTS);
    assign cnt_idx  = cnt_off[IDX_W+1:2];
    assign cnt_byte = cnt_off[1:0];

    // msb read freezes the whole count for the following byte reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_FAULTS; i++) begin
                snap[i] <= '0;
            end
        end else if (cnt_hit && cnt_byte == 2'd0) begin
            snap[cnt_idx] <= counts[cnt_idx];
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_next = '0;
        if (cnt_hit) begin
            case (cnt_byte)
                // live msb, same value the snapshot takes
                2'd0:    rd_next = counts[cnt_idx][31:24];
                2'd1:    rd_next = snap[cnt_idx][23:16];
                2'd2:    rd_next = snap[cnt_idx][15:8];
                default: rd_next = snap[cnt_idx][7:0];
            endcase
        end else begin
            case (addr)
                `ADDR_OSD_PAGE:   rd_next = {5'd0, osd_page};
                `ADDR_OSD_EN:     rd_next = {7'd0, enable_osd};
                `ADDR_HIGHLIGHT:  rd_next = highlight_line;
                `ADDR_RECONF:     rd_next = reconf_data;
                `ADDR_SCAN_HI:    rd_next = scanline.intensity[8:1];
                `ADDR_SCAN_LO: begin
                    rd_next = {scanline.intensity[0], scanline.thickness,
                               scanline.oddeven, scanline.active, 4'd0};
                end
                `ADDR_HDMI_EN:    rd_next = {7'd0, hdmi_out_en};
                `ADDR_COLORSPACE: rd_next = {6'd0, colorspace};
                // status levels, msb first
                `ADDR_STATUS_BASE:         rd_next = status_word[23:16];
                `ADDR_STATUS_BASE + 8'd1:  rd_next = status_word[15:8];
                `ADDR_STATUS_BASE + 8'd2:  rd_next = status_word[7:0];
                // unmapped and write-only addresses
                default:          rd_next = '0;
            endcase
        end
    end

    // read data follows addr one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else begin
            rdata <= rd_next;
        end
    end

endmodule : reg_map

// ==== design/fault_counter.sv ====
////////////////////////////////////////////////////////////////////////////
// fault event counter
// 32-bit count of event pulses, sticks at all ones, synchronous clear
////////////////////////////////////////////////////////////////////////////

module fault_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  event_pulse,
    input  logic                  clear,
    output video_regs_pkg::count_t count
);

    // count is full
    // further events are dropped
    logic sat;

    assign sat = &count;

    ////////////////////////////////////////////////////////////////////////
    // count update
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            // clear beats an event in the same cycle
            count <= '0;
        end else if (event_pulse && !sat) begin
            count <= count + 32'd1;
        end
    end

endmodule : fault_counter

// ==== design/fault_sync.sv ====
////////////////////////////////////////////////////////////////////////////
// fault line synchroniser
// brings the asynchronous fault levels into clk and registers a
// one-cycle pulse on each low-to-high transition
////////////////////////////////////////////////////////////////////////////

`include "video_regs_params.svh"

module fault_sync (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`NUM_FAULTS-1:0]   fault_in,
    output logic [`NUM_FAULTS-1:0]   fault_rise
);

    // first stage may go metastable
    logic [`NUM_FAULTS-1:0] meta;
    // stable synchronised level
    logic [`NUM_FAULTS-1:0] level;
    // level one cycle back for edge detect
    logic [`NUM_FAULTS-1:0] hist;

    ////////////////////////////////////////////////////////////////////////
    // two-flop synchroniser plus history stage
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta  <= '0;
            level <= '0;
            hist  <= '0;
        end else begin
            meta  <= fault_in;
            level <= meta;
            hist  <= level;
        end
    end

    // rising edge of the synced level
    // registered so the pulse is glitch free at the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_rise <= '0;
        end else begin
            fault_rise <= level & ~hist;
        end
    end

endmodule : fault_sync

// ==== design/video_regs_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// video scaler control registers
// shared register-map types for the config block, the fault counters
// and the register decode
////////////////////////////////////////////////////////////////////////////

package video_regs_pkg;

    // one byte on the host port
    // also the width of every plain config register
    typedef logic [7:0] reg_byte_t;

    // scanline setting as seen by the video pipeline
    // intensity is 9 bits, 0x100 is full strength
    typedef struct packed {
        logic [8:0] intensity;
        logic       thickness;
        logic       oddeven;
        logic       active;
    } scanline_t;

    // output colour space select
    typedef enum logic [1:0] {
        cs_rgb      = 2'd0,
        cs_ycbcr444 = 2'd1,
        cs_ycbcr422 = 2'd2,
        // not decoded downstream
        cs_reserved = 2'd3
    } colorspace_t;

    // fault event count
    // saturates instead of wrapping
    typedef logic [31:0] count_t;

endpackage : video_regs_pkg

// ==== include/video_regs_params.svh ====
////////////////////////////////////////////////////////////////////////////
// video scaler control registers
// fault line count and host register addresses
////////////////////////////////////////////////////////////////////////////

`ifndef VIDEO_REGS_PARAMS_SVH
`define VIDEO_REGS_PARAMS_SVH

// video pll, hot plug, 54 MHz pll, hdmi pll
`define NUM_FAULTS 4

////////////////////////////////////////////////////////////////////////////
// host register map
////////////////////////////////////////////////////////////////////////////

// below 0x80 goes to the osd character ram
`define ADDR_OSD_PAGE    8'h80
`define ADDR_OSD_EN      8'h81
`define ADDR_HIGHLIGHT   8'h82
`define ADDR_RECONF      8'h83

// scanline intensity msbs, then lsb and flags
`define ADDR_SCAN_HI     8'h88
`define ADDR_SCAN_LO     8'h89

`define ADDR_HDMI_EN     8'h91
`define ADDR_COLORSPACE  8'h93

// four bytes per counter, msb first
`define ADDR_CNT_BASE    8'hA0
// three status bytes, msb first
`define ADDR_STATUS_BASE 8'hB0

// write-only strobes
`define ADDR_CNT_CLEAR   8'hC1
`define ADDR_RESET_DC    8'hF0

`endif
